// ==== hdl/rvIsaPkg.sv ====
// RV32I word, address and register-index types, opcodes and funct3 codes
package rvIsaPkg;

    localparam int wordWidth   = 32;
    localparam int addrWidth   = 32;
    localparam int regIdxWidth = 5;

    typedef logic [wordWidth-1:0]   word_t;
    typedef logic [addrWidth-1:0]   addr_t;
    typedef logic [regIdxWidth-1:0] regIdx_t;

    // Major opcodes in instr[6:0]
    localparam logic [6:0] opOp     = 7'b0110011;
    localparam logic [6:0] opOpImm  = 7'b0010011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opAuipc  = 7'b0010111;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;

    // Load and store widths
    localparam logic [2:0] f3Byte   = 3'b000;
    localparam logic [2:0] f3Half   = 3'b001;
    localparam logic [2:0] f3Word   = 3'b010;
    localparam logic [2:0] f3ByteU  = 3'b100;
    localparam logic [2:0] f3HalfU  = 3'b101;

    // Integer ALU operations
    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Sll    = 3'b001;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Sltu   = 3'b011;
    localparam logic [2:0] f3Xor    = 3'b100;
    localparam logic [2:0] f3SrlSra = 3'b101;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;

endpackage

// ==== hdl/rvCtrlPkg.sv ====
// Datapath control encodings: ALU codes and classes, immediate formats, result and size selects
package rvCtrlPkg;

    typedef logic [3:0] aluCtrl_t;
    typedef logic [1:0] aluOp_t;
    typedef logic [2:0] immSrc_t;
    typedef logic [1:0] resultSrc_t;
    typedef logic [1:0] memSize_t;
    typedef logic [2:0] branchType_t;

    localparam aluCtrl_t aluAdd   = 4'd0;
    localparam aluCtrl_t aluSub   = 4'd1;
    localparam aluCtrl_t aluAnd   = 4'd2;
    localparam aluCtrl_t aluOr    = 4'd3;
    localparam aluCtrl_t aluXor   = 4'd4;
    localparam aluCtrl_t aluSll   = 4'd5;
    localparam aluCtrl_t aluSrl   = 4'd6;
    localparam aluCtrl_t aluSra   = 4'd7;
    localparam aluCtrl_t aluSlt   = 4'd8;
    localparam aluCtrl_t aluSltu  = 4'd9;
    localparam aluCtrl_t aluPassB = 4'd10; // LUI

    localparam aluOp_t aluOpAdd    = 2'd0; // Address and upper-immediate math
    localparam aluOp_t aluOpBranch = 2'd1;
    localparam aluOp_t aluOpFunct  = 2'd2; // Decoded from funct3/funct7

    localparam immSrc_t immI = 3'd0;
    localparam immSrc_t immS = 3'd1;
    localparam immSrc_t immB = 3'd2;
    localparam immSrc_t immU = 3'd3;
    localparam immSrc_t immJ = 3'd4;

    localparam resultSrc_t resAlu     = 2'd0;
    localparam resultSrc_t resMem     = 2'd1;
    localparam resultSrc_t resPcPlus4 = 2'd2; // Link value

    localparam memSize_t sizeByte = 2'd0;
    localparam memSize_t sizeHalf = 2'd1;
    localparam memSize_t sizeWord = 2'd2;

    // Branch types are the branch funct3 values
    localparam branchType_t brEq  = 3'b000;
    localparam branchType_t brNe  = 3'b001;
    localparam branchType_t brLt  = 3'b100;
    localparam branchType_t brGe  = 3'b101;
    localparam branchType_t brLtu = 3'b110;
    localparam branchType_t brGeu = 3'b111;

endpackage

// ==== hdl/aluDecoder.sv ====
// Second-level ALU decode from operation class, funct3 and funct7 bit 5
`timescale 1ns/1ns

module aluDecoder
    import rvIsaPkg::*;
    import rvCtrlPkg::*;
(
    input  aluOp_t     aluOp,
    input  logic [2:0] funct3,
    input  logic       funct7b5,
    input  logic [6:0] opcode,
    output aluCtrl_t   aluControl
);

    logic isRType;

    assign isRType = (opcode == opOp); // OP-IMM has no SUB

    always_comb begin
        aluControl = aluAdd;
        case (aluOp)
            aluOpAdd:    aluControl = (opcode == opLui) ? aluPassB : aluAdd;
            aluOpBranch: begin
                case (funct3)
                    brEq, brNe:   aluControl = aluSub;  // Zero flag tests equality
                    brLt, brGe:   aluControl = aluSlt;
                    brLtu, brGeu: aluControl = aluSltu;
                    default:      aluControl = aluSub;
                endcase
            end
            aluOpFunct: begin
                case (funct3)
                    f3AddSub: aluControl = (isRType && funct7b5) ? aluSub : aluAdd;
                    f3Sll:    aluControl = aluSll;
                    f3Slt:    aluControl = aluSlt;
                    f3Sltu:   aluControl = aluSltu;
                    f3Xor:    aluControl = aluXor;
                    f3SrlSra: aluControl = funct7b5 ? aluSra : aluSrl; // SRAI too
                    f3Or:     aluControl = aluOr;
                    f3And:    aluControl = aluAnd;
                    default:  aluControl = aluAdd;
                endcase
            end
            default:     aluControl = aluAdd;
        endcase
    end

endmodule

// ==== hdl/controlUnit.sv ====
// Main instruction decoder and branch-taken resolver
`timescale 1ns/1ns

module controlUnit
    import rvIsaPkg::*;
    import rvCtrlPkg::*;
(
    input  word_t      instr,
    input  logic       aluZero,     // Equality from SUB
    input  logic       aluResult0,  // Less-than bit from SLT/SLTU
    output aluCtrl_t   aluControl,
    output logic       aluSrc,      // Second operand is the immediate
    output logic       memWrite,
    output logic       regWrite,
    output resultSrc_t resultSrc,
    output immSrc_t    immSrc,
    output memSize_t   memSize,
    output logic       memUnsigned,
    output logic       jump,
    output logic       jumpReg,     // JALR target from rs1
    output logic       pcSrc
);

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic        funct7b5;
    aluOp_t      aluOp;
    logic        branch;
    branchType_t branchType;
    logic        branchTaken;

    assign opcode     = instr[6:0];
    assign funct3     = instr[14:12];
    assign funct7b5   = instr[30];
    assign branchType = funct3;

    always_comb begin
        regWrite    = 1'b0;
        resultSrc   = resAlu;
        aluSrc      = 1'b0;
        memWrite    = 1'b0;
        memSize     = sizeWord;
        memUnsigned = 1'b0;
        immSrc      = immI;
        aluOp       = aluOpAdd;
        branch      = 1'b0;
        jump        = 1'b0;
        jumpReg     = 1'b0;

        case (opcode)
            opOp: begin
                regWrite = 1'b1;
                aluOp    = aluOpFunct;
            end
            opOpImm: begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                aluOp    = aluOpFunct;
            end
            opLoad: begin
                regWrite  = 1'b1;
                resultSrc = resMem;
                aluSrc    = 1'b1; // rs1 + offset
                case (funct3)
                    f3Byte:  memSize = sizeByte;
                    f3Half:  memSize = sizeHalf;
                    f3Word:  memSize = sizeWord;
                    f3ByteU: begin
                        memSize     = sizeByte;
                        memUnsigned = 1'b1;
                    end
                    f3HalfU: begin
                        memSize     = sizeHalf;
                        memUnsigned = 1'b1;
                    end
                    default: memSize = sizeWord;
                endcase
            end
            opStore: begin
                memWrite = 1'b1;
                aluSrc   = 1'b1;
                immSrc   = immS;
                case (funct3)
                    f3Byte:  memSize = sizeByte;
                    f3Half:  memSize = sizeHalf;
                    f3Word:  memSize = sizeWord;
                    default: memSize = sizeWord;
                endcase
            end
            opBranch: begin
                branch = 1'b1;
                immSrc = immB;
                aluOp  = aluOpBranch; // Compare rs1 against rs2
            end
            opLui: begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                immSrc   = immU;
            end
            opAuipc: begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                immSrc   = immU;
            end
            opJal: begin
                regWrite  = 1'b1;
                resultSrc = resPcPlus4;
                immSrc    = immJ;
                jump      = 1'b1;
            end
            opJalr: begin
                regWrite  = 1'b1;
                resultSrc = resPcPlus4;
                aluSrc    = 1'b1;
                jump      = 1'b1;
                jumpReg   = 1'b1;
            end
            default: regWrite = 1'b0; // FENCE, SYSTEM and unknown act as NOP
        endcase
    end

    aluDecoder aluDec_i (
        .aluOp      (aluOp),
        .funct3     (funct3),
        .funct7b5   (funct7b5),
        .opcode     (opcode),
        .aluControl (aluControl)
    );

    branchComparator branchCmp_i (
        .zero        (aluZero),
        .aluResult0  (aluResult0),
        .branchType  (branchType),
        .branch      (branch),
        .branchTaken (branchTaken)
    );

    assign pcSrc = jump | branchTaken;

endmodule

module branchComparator
    import rvCtrlPkg::*;
(
    input  logic        zero,
    input  logic        aluResult0,
    input  branchType_t branchType,
    input  logic        branch,
    output logic        branchTaken
);

    logic cond;

    always_comb begin
        case (branchType)
            brEq:    cond = zero;
            brNe:    cond = ~zero;
            brLt:    cond = aluResult0;  // SLT result
            brGe:    cond = ~aluResult0;
            brLtu:   cond = aluResult0;  // SLTU result
            brGeu:   cond = ~aluResult0;
            default: cond = 1'b0;        // Reserved encodings never branch
        endcase
    end

    assign branchTaken = branch & cond;

endmodule

// ==== hdl/immExtend.sv ====
// Immediate assembly and sign extension for the I, S, B, U and J formats
`timescale 1ns/1ns

module immExtend
    import rvIsaPkg::*;
    import rvCtrlPkg::*;
(
    input  word_t   instr,
    input  immSrc_t immSrc,
    output word_t   imm
);

    always_comb begin
        case (immSrc)
            immI: imm = {{20{instr[31]}}, instr[31:20]};
            immS: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            immB: imm = {{20{instr[31]}}, instr[7], instr[30:25],
                         instr[11:8], 1'b0};              // Halfword offset
            immU: imm = {instr[31:12], 12'b0};
            immJ: imm = {{12{instr[31]}}, instr[19:12], instr[20],
                         instr[30:21], 1'b0};
            default: imm = {{20{instr[31]}}, instr[31:20]};
        endcase
    end

endmodule

// ==== hdl/aluUnit.sv ====
// 32-bit ALU with arithmetic, logic, shift, compare and pass-through, plus zero flag
`timescale 1ns/1ns

module aluUnit
    import rvIsaPkg::*;
    import rvCtrlPkg::*;
(
    input  word_t    a,
    input  word_t    b,
    input  aluCtrl_t aluControl,
    output word_t    result,
    output logic     zero
);

    logic [4:0] shamt;
    logic       ltSigned;
    logic       ltUnsigned;

    assign shamt      = b[4:0];
    assign ltSigned   = $signed(a) < $signed(b);
    assign ltUnsigned = a < b;

    always_comb begin
        case (aluControl)
            aluAdd:   result = a + b;
            aluSub:   result = a - b;
            aluAnd:   result = a & b;
            aluOr:    result = a | b;
            aluXor:   result = a ^ b;
            aluSll:   result = a << shamt;
            aluSrl:   result = a >> shamt;
            aluSra:   result = $unsigned($signed(a) >>> shamt);
            aluSlt:   result = {{(wordWidth-1){1'b0}}, ltSigned};
            aluSltu:  result = {{(wordWidth-1){1'b0}}, ltUnsigned};
            aluPassB: result = b;                   // Upper immediate straight through
            default:  result = a + b;
        endcase
    end

    assign zero = (result == '0);

endmodule

// ==== hdl/regFile.sv ====
// 32 x 32-bit register file, two combinational reads, one write, x0 hardwired to zero
`timescale 1ns/1ns

module regFile
    import rvIsaPkg::*;
(
    input  logic    clk,
    input  logic    arstN,
    input  regIdx_t rs1,
    input  regIdx_t rs2,
    input  regIdx_t rd,
    input  word_t   writeData,
    input  logic    regWrite,
    output word_t   rdData1,
    output word_t   rdData2
);

    word_t regs [2**regIdxWidth];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 2**regIdxWidth; i++) begin
                regs[i] <= '0;
            end
        end else if (regWrite && (rd != '0)) begin // x0 stays zero
            regs[rd] <= writeData;
        end
    end

    assign rdData1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdData2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== hdl/pcCounter.sv ====
// Program counter with increment by four and branch or jump target load
`timescale 1ns/1ns

module pcCounter
    import rvIsaPkg::*;
(
    input  logic  clk,
    input  logic  arstN,
    input  logic  pcSrc,   // Take target
    input  addr_t target,
    output addr_t pc,
    output addr_t pcPlus4
);

    assign pcPlus4 = pc + addr_t'(4);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;       // Reset vector
        end else if (pcSrc) begin
            pc <= target;
        end else begin
            pc <= pcPlus4;
        end
    end

endmodule

// ==== hdl/rvCore.sv ====
// Single-cycle RV32I core top: block wiring, operand and result muxes, load and store alignment
`timescale 1ns/1ns

module rvCore
    import rvIsaPkg::*;
    import rvCtrlPkg::*;
(
    input  logic       clk,
    input  logic       arstN,
    output addr_t      instrAddr,
    input  word_t      instr,
    output addr_t      dataAddr,
    output word_t      writeData,
    output logic       memWrite,
    output logic [3:0] memByteEn,
    input  word_t      readData
);

    aluCtrl_t   aluControl;
    logic       aluSrc;
    logic       regWrite;
    resultSrc_t resultSrc;
    immSrc_t    immSrc;
    memSize_t   memSize;
    logic       memUnsigned;
    logic       jump;
    logic       jumpReg;
    logic       pcSrc;

    addr_t      pc;
    addr_t      pcPlus4;
    addr_t      target;
    word_t      imm;
    word_t      rdData1;
    word_t      rdData2;
    word_t      srcA;
    word_t      srcB;
    word_t      aluResult;
    logic       aluZero;
    word_t      result;
    logic [1:0] byteOff;
    word_t      loadShifted;
    word_t      loadData;
    logic [3:0] laneEn;

    controlUnit ctrl_i (
        .instr       (instr),
        .aluZero     (aluZero),
        .aluResult0  (aluResult[0]),
        .aluControl  (aluControl),
        .aluSrc      (aluSrc),
        .memWrite    (memWrite),
        .regWrite    (regWrite),
        .resultSrc   (resultSrc),
        .immSrc      (immSrc),
        .memSize     (memSize),
        .memUnsigned (memUnsigned),
        .jump        (jump),
        .jumpReg     (jumpReg),
        .pcSrc       (pcSrc)
    );

    immExtend immExt_i (
        .instr  (instr),
        .immSrc (immSrc),
        .imm    (imm)
    );

    regFile regs_i (
        .clk       (clk),
        .arstN     (arstN),
        .rs1       (instr[19:15]),
        .rs2       (instr[24:20]),
        .rd        (instr[11:7]),
        .writeData (result),
        .regWrite  (regWrite),
        .rdData1   (rdData1),
        .rdData2   (rdData2)
    );

    assign srcA = (instr[6:0] == opAuipc) ? pc : rdData1; // AUIPC adds to the PC
    assign srcB = aluSrc ? imm : rdData2;

    aluUnit alu_i (
        .a          (srcA),
        .b          (srcB),
        .aluControl (aluControl),
        .result     (aluResult),
        .zero       (aluZero)
    );

    // JALR jumps to rs1 + imm with bit 0 cleared and all others are PC-relative
    assign target = (jump && jumpReg) ? {aluResult[31:1], 1'b0} : pc + imm;

    pcCounter pc_i (
        .clk     (clk),
        .arstN   (arstN),
        .pcSrc   (pcSrc),
        .target  (target),
        .pc      (pc),
        .pcPlus4 (pcPlus4)
    );

    assign instrAddr = pc;
    assign dataAddr  = aluResult;
    assign byteOff   = aluResult[1:0];

    always_comb begin
        case (memSize)
            sizeByte: begin
                writeData = {4{rdData2[7:0]}};        // Same byte on every lane
                laneEn    = 4'b0001 << byteOff;
            end
            sizeHalf: begin
                writeData = {2{rdData2[15:0]}};
                laneEn    = byteOff[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                writeData = rdData2;
                laneEn    = 4'b1111;
            end
        endcase
    end

    assign memByteEn = memWrite ? laneEn : 4'b0000;

    assign loadShifted = readData >> {byteOff, 3'b000}; // Addressed byte to lane 0

    always_comb begin
        case (memSize)
            sizeByte: loadData = memUnsigned ? {24'b0, loadShifted[7:0]}
                                             : {{24{loadShifted[7]}}, loadShifted[7:0]};
            sizeHalf: loadData = memUnsigned ? {16'b0, loadShifted[15:0]}
                                             : {{16{loadShifted[15]}}, loadShifted[15:0]};
            default:  loadData = loadShifted;
        endcase
    end

    always_comb begin
        case (resultSrc)
            resMem:     result = loadData;
            resPcPlus4: result = pcPlus4;  // Link for JAL/JALR
            default:    result = aluResult;
        endcase
    end

endmodule

// ==== tests/clockGen.sv ====
// Testbench clock and reset source
`timescale 1ns/1ns

module clockGen (
    output logic clk,
    output logic arstN
);

    initial clk = 1'b0;
    always #2 clk = ~clk;              // 4 ns period

    initial begin
        arstN = 1'b0;
        repeat (10) @(posedge clk);
        #1 arstN = 1'b1;               // Release just after a rising edge
    end

endmodule

// ==== tests/rvCore_properties.sv ====
// Bound concurrent assertions on the core's memory and fetch ports
`timescale 1ns/1ns

module rvCoreProperties
    import rvIsaPkg::*;
(
    input logic       clk,
    input logic       arstN,
    input addr_t      instrAddr,
    input logic       memWrite,
    input logic [3:0] memByteEn
);

    noStoreInReset: assert property (@(posedge clk) !arstN |-> !memWrite)
        else $error("memWrite high during reset");

    laneOnStore: assert property (@(posedge clk) disable iff (!arstN)
        memWrite |-> (memByteEn != 4'b0000))
        else $error("store with no byte enabled");

    fetchAligned: assert property (@(posedge clk) disable iff (!arstN)
        instrAddr[1:0] == 2'b00)
        else $error("instrAddr not word aligned");

    startAtZero: assert property (@(posedge clk) $rose(arstN) |-> (instrAddr == '0))
        else $error("instrAddr not zero after reset");

endmodule

bind rvCore rvCoreProperties props_i (
    .clk       (clk),
    .arstN     (arstN),
    .instrAddr (instrAddr),
    .memWrite  (memWrite),
    .memByteEn (memByteEn)
);

// ==== tests/rvCoreTb.sv ====
// Table-driven testbench for rvCore with instruction and data memory models
`timescale 1ns/1ns

module rvCoreTb
    import rvIsaPkg::*;
(
);

    localparam word_t nopInstr = 32'h0000_0013;   // addi x0, x0, 0
    localparam word_t loadWord = 32'h8765_F0A1;   // Preloaded at 0x200
    localparam word_t padInstr = 32'h7E00_2E23;   // sw x0, 0x7FC(x0) on a skipped slot

    logic       clk;
    logic       arstN;
    addr_t      instrAddr;
    word_t      instr;
    addr_t      dataAddr;
    word_t      writeData;
    logic       memWrite;
    logic [3:0] memByteEn;
    word_t      readData;

    word_t      prog [128];                        // Instruction table indexed by word address
    word_t      nextAddr [128];
    logic       isStore [128];
    addr_t      expAddr [128];
    word_t      expData [128];
    logic [3:0] expBe [128];
    int         grpOf [128];
    word_t      dataMem [1024];
    string      grpName [6];
    int         grpErr [6];
    int         grpSteps [6];
    word_t      fillAddr;
    int         fillGrp;
    addr_t      endAddr;
    logic [6:0] idx;
    logic [6:0] prevIdx;
    logic       havePrev;
    int         errors;
    int         steps;
    int         cycles;

    clockGen clkGen_i (.clk(clk), .arstN(arstN));

    rvCore dut_i (
        .clk       (clk),
        .arstN     (arstN),
        .instrAddr (instrAddr),
        .instr     (instr),
        .dataAddr  (dataAddr),
        .writeData (writeData),
        .memWrite  (memWrite),
        .memByteEn (memByteEn),
        .readData  (readData)
    );

    assign readData = dataMem[dataAddr[11:2]];    // Combinational load port

    always @(posedge clk) begin
        if (memWrite) begin
            for (int k = 0; k < 4; k++) begin
                if (memByteEn[k]) dataMem[dataAddr[11:2]][8*k +: 8] <= writeData[8*k +: 8];
            end
        end
    end

    function automatic word_t encR(logic [6:0] f7, logic [31:0] rs2, logic [31:0] rs1,
                                   logic [2:0] f3, logic [31:0] rd);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], opOp};
    endfunction

    function automatic word_t encI(logic [31:0] imm, logic [31:0] rs1, logic [2:0] f3,
                                   logic [31:0] rd, logic [6:0] op);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
    endfunction

    function automatic word_t encS(logic [31:0] imm, logic [31:0] rs2, logic [2:0] f3);
        return {imm[11:5], rs2[4:0], 5'd0, f3, imm[4:0], opStore}; // Base is x0
    endfunction

    function automatic word_t encB(logic [31:0] rs1, logic [31:0] rs2, logic [2:0] f3);
        logic [12:0] off;
        off = 13'd8;                                // Every taken branch skips one slot
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], opBranch};
    endfunction

    function automatic word_t encU(logic [19:0] imm, logic [31:0] rd, logic [6:0] op);
        return {imm, rd[4:0], op};
    endfunction

    function automatic word_t encJ(logic [31:0] off, logic [31:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], opJal};
    endfunction

    task automatic putEntry(word_t ins, word_t nxt, logic st, addr_t a, word_t d,
                            logic [3:0] be);
        prog[fillAddr[8:2]]     = ins;
        nextAddr[fillAddr[8:2]] = nxt;
        isStore[fillAddr[8:2]]  = st;
        expAddr[fillAddr[8:2]]  = a;
        expData[fillAddr[8:2]]  = d;
        expBe[fillAddr[8:2]]    = be;
        grpOf[fillAddr[8:2]]    = fillGrp;
        fillAddr                = fillAddr + 4;
    endtask

    task automatic addOp(word_t ins);
        putEntry(ins, fillAddr + 4, 1'b0, '0, '0, 4'b0000);
    endtask

    task automatic addStore(word_t ins, addr_t a, word_t d, logic [3:0] be);
        putEntry(ins, fillAddr + 4, 1'b1, a, d, be);
    endtask

    task automatic addStoreWord(logic [31:0] rs2, word_t d);
        addStore(encS(32'h400, rs2, f3Word), 32'h400, d, 4'b1111);
    endtask

    task automatic addBranch(logic [2:0] f3, logic [31:0] rs1, logic [31:0] rs2, logic taken);
        if (taken) begin
            putEntry(encB(rs1, rs2, f3), fillAddr + 8, 1'b0, '0, '0, 4'b0000);
            addOp(padInstr);                        // Must never execute
        end else begin
            addOp(encB(rs1, rs2, f3));
        end
    endtask

    task automatic checkValue(string name, word_t exp, word_t act, int g);
        if (act !== exp) begin
            $display("MISMATCH t=%0t %s expected %h actual %h", $time, name, exp, act);
            errors++;
            grpErr[g]++;
        end
    endtask

    task automatic checkStep(logic [6:0] i);
        grpSteps[grpOf[i]]++;
        steps++;
        checkValue("instrAddr", nextAddr[i], instrAddr, grpOf[i]);
        checkValue("memWrite", {31'b0, isStore[i]}, {31'b0, memWrite}, grpOf[i]);
        if (isStore[i]) begin
            checkValue("dataAddr", expAddr[i], dataAddr, grpOf[i]);
            checkValue("writeData", expData[i], writeData, grpOf[i]);
            checkValue("memByteEn", {28'b0, expBe[i]}, {28'b0, memByteEn}, grpOf[i]);
        end
    endtask

    task automatic reportGroup(int g);
        $display("%s: %0d steps, %0d errors", grpName[g], grpSteps[g], grpErr[g]);
    endtask

    always @(negedge clk) begin
        if (!arstN) begin
            if (memWrite) begin
                $display("Store issued while reset is asserted at t=%0t", $time);
                errors++;
                grpErr[5]++;
            end
        end else begin
            if (havePrev) begin
                checkStep(prevIdx);
            end else begin
                checkValue("instrAddr", '0, instrAddr, 5);
                reportGroup(5);
            end
            idx = instrAddr[8:2];
            if (havePrev && grpOf[idx] != grpOf[prevIdx]) reportGroup(grpOf[prevIdx]);
            instr   <= prog[idx];
            prevIdx = idx;
            havePrev = 1'b1;
        end
    end

    initial begin
        word_t a;
        word_t b;
        word_t markAddr;
        instr    = nopInstr;                     // NOP while reset is held
        havePrev = 1'b0;
        errors   = 0;
        steps    = 0;
        grpName  = '{"alu", "upper", "memory", "branch", "jump", "reset"};
        for (int g = 0; g < 6; g++) begin
            grpErr[g]   = 0;
            grpSteps[g] = 0;
        end
        for (int i = 0; i < 1024; i++) dataMem[i] = {i[15:0] ^ 16'hA5A5, i[15:0]};
        dataMem[128] = loadWord;
        for (int i = 0; i < 128; i++) begin
            prog[i]     = nopInstr;
            nextAddr[i] = word_t'(i * 4 + 4);
            isStore[i]  = 1'b0;
            grpOf[i]    = 0;
        end

        a        = 32'd5;                         // x1
        b        = 32'hFFFF_FFFD;                 // x2
        fillAddr = '0;
        fillGrp  = 0;
        addOp(encI(a, 0, f3AddSub, 1, opOpImm));
        addStoreWord(1, a);
        addOp(encI(b, 0, f3AddSub, 2, opOpImm));
        addStoreWord(2, b);
        addOp(encR(7'h00, 2, 1, f3AddSub, 3));
        addStoreWord(3, a + b);
        addOp(encR(7'h20, 2, 1, f3AddSub, 4));
        addStoreWord(4, a - b);
        addOp(encR(7'h00, 2, 1, f3And, 5));
        addStoreWord(5, a & b);
        addOp(encR(7'h00, 2, 1, f3Or, 6));
        addStoreWord(6, a | b);
        addOp(encR(7'h00, 2, 1, f3Xor, 7));
        addStoreWord(7, a ^ b);
        addOp(encR(7'h00, 1, 1, f3Sll, 8));
        addStoreWord(8, a << 5);
        addOp(encR(7'h00, 1, 2, f3SrlSra, 9));
        addStoreWord(9, b >> 5);
        addOp(encR(7'h20, 1, 2, f3SrlSra, 10));
        addStoreWord(10, 32'hFFFF_FFFF);           // -3 shifted right arithmetically by 5
        addOp(encI(32'h401, 2, f3SrlSra, 11, opOpImm));
        addStoreWord(11, 32'hFFFF_FFFE);
        addOp(encR(7'h00, 1, 2, f3Slt, 12));
        addStoreWord(12, 32'd1);
        addOp(encR(7'h00, 1, 2, f3Sltu, 13));
        addStoreWord(13, 32'd0);
        addOp(encI(32'd7, 0, f3AddSub, 0, opOpImm));
        addStoreWord(0, 32'd0);

        fillGrp = 1;
        addOp(encU(20'h12345, 14, opLui));
        addStoreWord(14, 32'h1234_5000);
        markAddr = fillAddr;
        addOp(encU(20'h00001, 15, opAuipc));
        addStoreWord(15, markAddr + 32'h1000);

        fillGrp = 2;
        addOp(encI(32'h200, 0, f3Word, 16, opLoad));
        addStoreWord(16, loadWord);
        addStore(encS(32'h400, 16, f3Byte), 32'h400, 32'hA1A1_A1A1, 4'b0001);
        addStore(encS(32'h401, 16, f3Byte), 32'h401, 32'hA1A1_A1A1, 4'b0010);
        addStore(encS(32'h402, 16, f3Byte), 32'h402, 32'hA1A1_A1A1, 4'b0100);
        addStore(encS(32'h403, 16, f3Byte), 32'h403, 32'hA1A1_A1A1, 4'b1000);
        addStore(encS(32'h400, 16, f3Half), 32'h400, 32'hF0A1_F0A1, 4'b0011);
        addStore(encS(32'h402, 16, f3Half), 32'h402, 32'hF0A1_F0A1, 4'b1100);
        addOp(encI(32'h200, 0, f3Byte, 17, opLoad));
        addStoreWord(17, 32'hFFFF_FFA1);
        addOp(encI(32'h201, 0, f3ByteU, 18, opLoad));
        addStoreWord(18, 32'h0000_00F0);
        addOp(encI(32'h202, 0, f3Half, 19, opLoad));
        addStoreWord(19, 32'hFFFF_8765);
        addOp(encI(32'h200, 0, f3HalfU, 20, opLoad));
        addStoreWord(20, 32'h0000_F0A1);
        addOp(encI(32'h203, 0, f3Byte, 21, opLoad));
        addStoreWord(21, 32'hFFFF_FF87);

        fillGrp = 3;                              // x1 = 5, x2 = -3
        addBranch(3'b000, 1, 1, 1'b1);
        addBranch(3'b000, 1, 2, 1'b0);
        addBranch(3'b001, 1, 2, 1'b1);
        addBranch(3'b001, 1, 1, 1'b0);
        addBranch(3'b100, 2, 1, 1'b1);
        addBranch(3'b100, 1, 2, 1'b0);
        addBranch(3'b101, 1, 2, 1'b1);
        addBranch(3'b101, 2, 1, 1'b0);
        addBranch(3'b110, 1, 2, 1'b1);
        addBranch(3'b110, 2, 1, 1'b0);
        addBranch(3'b111, 2, 1, 1'b1);
        addBranch(3'b111, 1, 2, 1'b0);

        fillGrp  = 4;
        markAddr = fillAddr;
        putEntry(encJ(32'd8, 22), fillAddr + 8, 1'b0, '0, '0, 4'b0000);
        addOp(padInstr);
        addStoreWord(22, markAddr + 4);
        addOp(encI(fillAddr + 12, 0, f3AddSub, 24, opOpImm)); // JALR adds 1 to this even target
        markAddr = fillAddr;
        putEntry(encI(32'd1, 24, 3'b000, 23, opJalr), markAddr + 8, 1'b0, '0, '0, 4'b0000);
        addOp(padInstr);
        addStoreWord(23, markAddr + 4);
        endAddr = fillAddr;
        putEntry(encJ(32'd0, 0), fillAddr, 1'b0, '0, '0, 4'b0000); // Spin here at the end

        cycles = 0;
        while (arstN !== 1'b1 && cycles < 100) begin
            @(posedge clk);
            cycles++;
        end
        cycles = 0;
        while (!(havePrev && instrAddr == endAddr) && cycles < 1000) begin
            @(negedge clk);
            cycles++;
        end
        if (!(havePrev && instrAddr == endAddr)) begin
            $display("Timeout: program end was never reached");
            $display("Simulation finished: FAIL");
            $finish;
        end else begin
            @(posedge clk);
            reportGroup(4);
            $display("Totals: %0d steps, %0d errors", steps, errors);
            if (errors == 0) begin
                $display("Simulation finished: PASS");
            end else begin
                $display("Simulation finished: FAIL");
            end
            $finish;
        end
    end

endmodule

// ==== sources.f ====
hdl/rvIsaPkg.sv
hdl/rvCtrlPkg.sv
hdl/aluDecoder.sv
hdl/controlUnit.sv
hdl/immExtend.sv
hdl/aluUnit.sv
hdl/regFile.sv
hdl/pcCounter.sv
hdl/rvCore.sv
tests/clockGen.sv
tests/rvCore_properties.sv
tests/rvCoreTb.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the rvCore testbench with Verilator

verilator --binary --timing --assert --top-module rvCoreTb -f sources.f \
    --Mdir obj_dir -o rvCoreSim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/rvCoreSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "Simulation finished: PASS" sim.log; then
    exit 0
fi
exit 1
